/* common/trig_pkg.sv */
// Trigger shared definitions
package trig_pkg;

   // sample layout per clklvds cycle
   localparam int n_samples = 40;  // samples per clock
   localparam int n_groups  = 4;   // even groups ch0, odd groups ch1
   localparam int group_len = 10;  // samples per group

   typedef logic signed [11:0] sample_t;      // one adc sample
   typedef logic [9:0]         ram_addr_t;    // circular ram write address
   typedef logic [15:0]        length_t;      // pre/post write counts
   typedef logic [7:0]         tot_t;         // time over threshold
   typedef logic [7:0]         merge_t;       // merge factor and counter
   typedef logic [4:0]         downsample_t;  // log2 decimation
   typedef logic [31:0]        event_count_t; // completed events

   // trigger types as written by software
   typedef enum logic [7:0] {
      trig_off     = 8'd0,
      trig_rising  = 8'd1,  // below low, then above high
      trig_falling = 8'd2,  // above high, then below low
      trig_lvds    = 8'd3,  // from neighbour board
      trig_auto    = 8'd4,  // forced capture
      trig_ext     = 8'd5   // back panel with tot
   } trig_type_t;

   // acquisition states
   typedef enum logic [3:0] {
      s_ready,
      s_pre,        // filling pre-trigger window
      s_arm,        // first threshold condition
      s_fire,       // second condition with tot
      s_wait_lvds,
      s_auto,
      s_wait_ext,
      s_post,       // filling post-trigger window
      s_done        // waiting for readout
   } acq_state_t;

   // the back-panel path lags the sample stream by a few writes
   localparam ram_addr_t ext_trig_delay = 10'd3;

endpackage

/* logic/config_sync.sv */
// Configuration retiming
`timescale 1ns/1ps

module config_sync (
   input  logic                   clklvds,
   input  logic                   arst_n,
   input  trig_pkg::sample_t      lowerthresh,
   input  trig_pkg::sample_t      upperthresh,
   input  trig_pkg::length_t      lengthtotake,
   input  trig_pkg::length_t      prelengthtotake,
   input  logic                   triggerlive,
   input  logic                   didreadout,
   input  logic [7:0]             triggertype,
   input  trig_pkg::tot_t         triggertot,
   input  logic                   triggerchan,
   input  logic [7:0]             channeltype,
   input  trig_pkg::merge_t       downsamplemerging,
   input  trig_pkg::downsample_t  downsample,
   output trig_pkg::sample_t      lowerthresh_sync,
   output trig_pkg::sample_t      upperthresh_sync,
   output trig_pkg::length_t      lengthtotake_sync,
   output trig_pkg::length_t      prelengthtotake_sync,
   output logic                   triggerlive_sync,
   output logic                   didreadout_sync,
   output trig_pkg::trig_type_t   triggertype_sync,
   output trig_pkg::tot_t         triggertot_sync,
   output logic                   triggerchan_sync,
   output logic                   channeltype_sync,
   output trig_pkg::merge_t       downsamplemerging_sync,
   output trig_pkg::downsample_t  downsample_sync
);
   import trig_pkg::*;

   always_ff @(posedge clklvds or negedge arst_n) begin
      if (!arst_n) begin
         lowerthresh_sync       <= '0;
         upperthresh_sync       <= '0;
         lengthtotake_sync      <= '0;
         prelengthtotake_sync   <= '0;
         triggerlive_sync       <= 1'b0;
         didreadout_sync        <= 1'b0;
         triggertype_sync       <= trig_off;
         triggertot_sync        <= '0;
         triggerchan_sync       <= 1'b0;
         channeltype_sync       <= 1'b0;
         downsamplemerging_sync <= '0;
         downsample_sync        <= '0;
      end else begin
         lowerthresh_sync       <= lowerthresh;
         upperthresh_sync       <= upperthresh;
         lengthtotake_sync      <= lengthtotake;
         prelengthtotake_sync   <= prelengthtotake;
         triggerlive_sync       <= triggerlive;
         didreadout_sync        <= didreadout;
         triggertype_sync       <= trig_type_t'(triggertype); // raw code, unknown values stay idle
         triggertot_sync        <= triggertot;
         triggerchan_sync       <= triggerchan;
         channeltype_sync       <= channeltype[0];            // two-channel flag only
         downsamplemerging_sync <= downsamplemerging;
         downsample_sync        <= downsample;
      end
   end

endmodule

/* logic/sample_pacer.sv */
// RAM write pacing
`timescale 1ns/1ps

module sample_pacer (
   input  logic                   clklvds,
   input  logic                   arst_n,
   input  logic                   acq_active,
   input  trig_pkg::downsample_t  downsample,
   input  trig_pkg::merge_t       merge,
   output logic                   ram_wr,
   output trig_pkg::ram_addr_t    ram_wr_address
);
   import trig_pkg::*;

   logic [31:0] dec_cnt;   // runs 1 .. 2^downsample
   merge_t      merge_cnt; // runs 1 .. merge
   merge_t      merge_eff;
   logic        dec_tick;

   assign merge_eff = (merge == '0) ? merge_t'(1) : merge; // 0 behaves as 1
   assign dec_tick  = dec_cnt[downsample];                 // reached 2^downsample

   always_ff @(posedge clklvds or negedge arst_n) begin
      if (!arst_n) begin
         dec_cnt        <= 32'd1;
         merge_cnt      <= merge_t'(1);
         ram_wr         <= 1'b0;
         ram_wr_address <= '0;
      end else if (!acq_active) begin
         dec_cnt   <= 32'd1; // idle, restart pacing, keep address
         merge_cnt <= merge_t'(1);
         ram_wr    <= 1'b0;
      end else if (dec_tick) begin
         dec_cnt <= 32'd1;
         if (merge_cnt >= merge_eff) begin // >= copes with merge lowered on the fly
            merge_cnt      <= merge_t'(1);
            ram_wr         <= 1'b1;
            ram_wr_address <= ram_wr_address + 10'd1; // wraps at 1024
         end else begin
            merge_cnt <= merge_cnt + 8'd1;
            ram_wr    <= 1'b0;
         end
      end else begin
         dec_cnt <= dec_cnt + 32'd1;
         ram_wr  <= 1'b0;
      end
   end

   // writes only follow an active cycle
   a_no_wr_idle : assert property (@(posedge clklvds) disable iff (!arst_n)
      !$past(acq_active) |-> !ram_wr);

endmodule

/* logic/threshold_compare.sv */
// Threshold comparison
`timescale 1ns/1ps

module threshold_compare (
   input  logic               clklvds,
   input  logic               arst_n,
   input  trig_pkg::sample_t  samplevalue [trig_pkg::n_samples],
   input  trig_pkg::sample_t  lowerthresh,
   input  trig_pkg::sample_t  upperthresh,
   input  logic               two_channel,
   input  logic               triggerchan,
   output logic               below_any,
   output logic               above_any
);
   import trig_pkg::*;

   logic [n_groups-1:0] grp_en; // groups taking part
   logic                below_c;
   logic                above_c;

   // channel masking, even groups ch0 and odd groups ch1
   always_comb begin
      for (int g = 0; g < n_groups; g++) begin
         grp_en[g] = !two_channel || (triggerchan == g[0]);
      end
   end

   // 40-way compare, signed
   always_comb begin
      below_c = 1'b0;
      above_c = 1'b0;
      for (int g = 0; g < n_groups; g++) begin
         for (int k = 0; k < group_len; k++) begin
            if (grp_en[g] && (samplevalue[g*group_len + k] < lowerthresh)) begin
               below_c = 1'b1;
            end
            if (grp_en[g] && (samplevalue[g*group_len + k] > upperthresh)) begin
               above_c = 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clklvds or negedge arst_n) begin
      if (!arst_n) begin
         below_any <= 1'b0;
         above_any <= 1'b0;
      end else begin
         below_any <= below_c; // one cycle behind samples
         above_any <= above_c;
      end
   end

endmodule

/* logic/ext_trig_detect.sv */
// Back-panel trigger detection
`timescale 1ns/1ps

module ext_trig_detect (
   input  logic            clklvds,
   input  logic            arst_n,
   input  logic            exttrigin,
   input  logic            arm_ext,
   input  trig_pkg::tot_t  triggertot,
   output logic            ext_fire
);
   import trig_pkg::*;

   logic ext_meta;       // first sync stage
   logic ext_sync;       // second sync stage
   logic ext_last;       // for edge find
   logic ext_seen;       // rising edge remembered while armed
   tot_t ext_high_count; // cycles high since edge

   always_ff @(posedge clklvds or negedge arst_n) begin
      if (!arst_n) begin
         ext_meta       <= 1'b0;
         ext_sync       <= 1'b0;
         ext_last       <= 1'b0;
         ext_seen       <= 1'b0;
         ext_high_count <= '0;
      end else begin
         ext_meta <= exttrigin;
         ext_sync <= ext_meta;
         ext_last <= ext_sync;
         if (!arm_ext) begin
            ext_seen <= 1'b0; // disarmed, forget any edge
         end else if (ext_sync && !ext_last) begin
            ext_seen <= 1'b1;
         end
         if (!ext_sync || !arm_ext) begin
            ext_high_count <= '0; // pulse ended
         end else if (ext_seen && ext_high_count != '1) begin
            ext_high_count <= ext_high_count + 8'd1; // saturates
         end
      end
   end

   assign ext_fire = ext_seen && (ext_high_count >= triggertot);

endmodule

/* acquisition/acq_fsm.sv */
// Acquisition state machine
`timescale 1ns/1ps

module acq_fsm (
   input  logic                    clklvds,
   input  logic                    arst_n,
   input  trig_pkg::trig_type_t    triggertype,
   input  logic                    triggerlive,
   input  logic                    didreadout,
   input  trig_pkg::length_t       prelengthtotake,
   input  trig_pkg::length_t       lengthtotake,
   input  trig_pkg::tot_t          triggertot,
   input  logic                    ram_wr,
   input  trig_pkg::ram_addr_t     ram_wr_address,
   input  logic                    below_any,
   input  logic                    above_any,
   input  logic                    lvdsin_trig,
   input  logic                    ext_fire,
   output logic                    acq_active,
   output logic                    arm_ext,
   output trig_pkg::acq_state_t    acqstate,
   output trig_pkg::ram_addr_t     ram_address_triggered,
   output trig_pkg::event_count_t  eventcounter,
   output logic                    lvdsout_trig,
   output logic                    auxout
);
   import trig_pkg::*;

   acq_state_t state;
   trig_type_t cur_type;  // type captured on leaving s_ready
   length_t    wr_count;  // pre and post write counter
   tot_t       tot_count; // writes with second condition held
   logic       rising;
   logic       fire_flag; // second threshold condition
   logic       abort;     // type changed while waiting
   logic       trig_hit;
   ram_addr_t  trig_addr;

   assign rising     = (cur_type == trig_rising);
   assign fire_flag  = rising ? above_any : below_any;
   assign abort      = (triggertype != cur_type) &&
                       (state inside {s_pre, s_arm, s_fire, s_wait_lvds, s_auto, s_wait_ext});
   assign acq_active = (state != s_ready) && (state != s_done);
   assign arm_ext    = (state == s_wait_ext);
   assign acqstate   = state;

   // trigger conditions per waiting state
   always_comb begin
      trig_hit = 1'b0;
      case (state)
         s_fire:      trig_hit = fire_flag && (tot_count >= triggertot);
         s_wait_lvds: trig_hit = lvdsin_trig;
         s_auto:      trig_hit = 1'b1;
         s_wait_ext:  trig_hit = ext_fire;
         default:     trig_hit = 1'b0;
      endcase
   end

   // back off by tot, ext adds its path delay
   assign trig_addr = ram_wr_address - ram_addr_t'(triggertot) +
                      ((cur_type == trig_ext) ? ext_trig_delay : ram_addr_t'(0));

   always_ff @(posedge clklvds or negedge arst_n) begin
      if (!arst_n) begin
         state                 <= s_ready;
         cur_type              <= trig_off;
         wr_count              <= '0;
         tot_count             <= '0;
         ram_address_triggered <= '0;
         eventcounter          <= '0;
         lvdsout_trig          <= 1'b0;
         auxout                <= 1'b0;
      end else begin
         lvdsout_trig <= 1'b0;
         if (abort) begin
            state <= s_ready;
         end else if (trig_hit) begin
            ram_address_triggered <= trig_addr;
            lvdsout_trig          <= (cur_type != trig_lvds); // lvds triggers not re-sent
            auxout                <= 1'b1;
            wr_count              <= '0;
            state                 <= s_post;
         end else begin
            case (state)
               s_ready: begin
                  cur_type  <= triggertype;
                  wr_count  <= '0;
                  tot_count <= '0;
                  if (triggertype != trig_off && triggerlive) state <= s_pre;
               end
               s_pre: begin
                  if (wr_count < prelengthtotake) begin
                     if (ram_wr) wr_count <= wr_count + 16'd1;
                  end else begin
                     wr_count <= '0;
                     case (cur_type)
                        trig_rising, trig_falling: state <= s_arm;
                        trig_lvds:                 state <= s_wait_lvds;
                        trig_auto:                 state <= s_auto;
                        trig_ext:                  state <= s_wait_ext;
                        default:                   state <= s_ready;
                     endcase
                  end
               end
               s_arm: begin
                  tot_count <= '0;
                  if (rising ? below_any : above_any) state <= s_fire; // first condition
               end
               s_fire: begin
                  if (fire_flag && ram_wr) tot_count <= tot_count + 8'd1;
               end
               s_post: begin
                  if (wr_count < lengthtotake) begin
                     if (ram_wr) wr_count <= wr_count + 16'd1;
                  end else begin
                     eventcounter <= eventcounter + 32'd1;
                     auxout       <= 1'b0;
                     state        <= s_done;
                  end
               end
               s_done: begin
                  wr_count <= '0;
                  if (didreadout) state <= s_ready;
               end
               s_wait_lvds, s_auto, s_wait_ext: ; // waiting on trig_hit
               default: state <= s_ready;
            endcase
         end
      end
   end

   // one trigger pulse per event
   a_lvdsout_single : assert property (@(posedge clklvds) disable iff (!arst_n)
      lvdsout_trig |=> !lvdsout_trig);

   // events count only when post window completes
   a_event_on_done : assert property (@(posedge clklvds) disable iff (!arst_n)
      $changed(eventcounter) |-> (state == s_done) && ($past(state) == s_post));

endmodule

/* logic/triggerer_top.sv */
// Acquisition trigger top
`timescale 1ns/1ps

module triggerer_top (
   input  logic                    clklvds,
   input  logic                    arst_n,
   input  trig_pkg::sample_t       samplevalue [trig_pkg::n_samples],
   input  logic                    lvdsin_trig,
   input  logic                    exttrigin,
   input  trig_pkg::sample_t       lowerthresh,
   input  trig_pkg::sample_t       upperthresh,
   input  trig_pkg::length_t       lengthtotake,
   input  trig_pkg::length_t       prelengthtotake,
   input  logic                    triggerlive,
   input  logic                    didreadout,
   input  logic [7:0]              triggertype,
   input  trig_pkg::tot_t          triggertot,
   input  logic                    triggerchan,
   input  logic [7:0]              channeltype,
   input  trig_pkg::merge_t        downsamplemerging,
   input  trig_pkg::downsample_t   downsample,
   output logic                    ram_wr,
   output trig_pkg::ram_addr_t     ram_wr_address,
   output trig_pkg::ram_addr_t     ram_address_triggered,
   output trig_pkg::acq_state_t    acqstate,
   output trig_pkg::event_count_t  eventcounter,
   output logic                    lvdsout_trig,
   output logic                    auxout
);
   import trig_pkg::*;

   sample_t     lowerthresh_sync, upperthresh_sync;
   length_t     lengthtotake_sync, prelengthtotake_sync;
   logic        triggerlive_sync, didreadout_sync;
   trig_type_t  triggertype_sync;
   tot_t        triggertot_sync;
   logic        triggerchan_sync, channeltype_sync;
   merge_t      downsamplemerging_sync;
   downsample_t downsample_sync;
   logic        below_any, above_any; // threshold flags
   logic        ext_fire, arm_ext;    // back-panel path
   logic        acq_active;           // enables write pacing

   config_sync i_config_sync (
      .clklvds, .arst_n, .lowerthresh, .upperthresh, .lengthtotake, .prelengthtotake,
      .triggerlive, .didreadout, .triggertype, .triggertot, .triggerchan, .channeltype,
      .downsamplemerging, .downsample, .lowerthresh_sync, .upperthresh_sync,
      .lengthtotake_sync, .prelengthtotake_sync, .triggerlive_sync, .didreadout_sync,
      .triggertype_sync, .triggertot_sync, .triggerchan_sync, .channeltype_sync,
      .downsamplemerging_sync, .downsample_sync);

   threshold_compare i_threshold_compare (
      .clklvds, .arst_n, .samplevalue,
      .lowerthresh (lowerthresh_sync),
      .upperthresh (upperthresh_sync),
      .two_channel (channeltype_sync),
      .triggerchan (triggerchan_sync),
      .below_any, .above_any);

   ext_trig_detect i_ext_trig_detect (
      .clklvds, .arst_n, .exttrigin, .arm_ext,
      .triggertot (triggertot_sync),
      .ext_fire);

   sample_pacer i_sample_pacer (
      .clklvds, .arst_n, .acq_active,
      .downsample (downsample_sync),
      .merge      (downsamplemerging_sync),
      .ram_wr, .ram_wr_address);

   acq_fsm i_acq_fsm (
      .clklvds, .arst_n,
      .triggertype     (triggertype_sync),
      .triggerlive     (triggerlive_sync),
      .didreadout      (didreadout_sync),
      .prelengthtotake (prelengthtotake_sync),
      .lengthtotake    (lengthtotake_sync),
      .triggertot      (triggertot_sync),
      .ram_wr, .ram_wr_address, .below_any, .above_any, .lvdsin_trig, .ext_fire,
      .acq_active, .arm_ext, .acqstate, .ram_address_triggered, .eventcounter,
      .lvdsout_trig, .auxout);

endmodule

/* verification/tb_triggerer.sv */
// Trigger testbench
`timescale 1ns/1ps

module tb_triggerer;
   import trig_pkg::*;

   logic         clklvds = 1'b0;
   logic         arst_n;
   sample_t      samplevalue [n_samples];
   logic         lvdsin_trig, exttrigin, triggerlive, didreadout, triggerchan;
   sample_t      lowerthresh, upperthresh;
   length_t      lengthtotake, prelengthtotake;
   logic [7:0]   triggertype, channeltype;
   tot_t         triggertot;
   merge_t       downsamplemerging;
   downsample_t  downsample;
   logic         ram_wr, lvdsout_trig, auxout;
   ram_addr_t    ram_wr_address, ram_address_triggered;
   acq_state_t   acqstate;
   event_count_t eventcounter;

   integer       seed = 32'hea0cc618; // noise seed
   int           low_idx = -1;        // sample forced below lowerthresh
   int           high_idx = -1;       // sample forced above upperthresh
   int           cycle = 0;
   int           last_wr_cycle = 0;
   int           post_wr = 0;         // strobes seen while in s_post
   int           pulses = 0;          // lvdsout_trig pulses of this event
   ram_addr_t    last_addr = '0, prev_addr = '0;
   ram_addr_t    exp_tot = 10'd2, exp_delay = 10'd0; // address back-off rule
   acq_state_t   prev_state = s_ready;
   event_count_t prev_events = '0;
   logic         rst_q = 1'b0, prev_wr = 1'b0, addr_valid = 1'b0, pace_valid = 1'b0;
   logic         check_pace = 1'b0; // spacing check window
   logic         trig_ok = 1'b0;    // a trigger may fire now
   logic         resend_ok = 1'b0;  // trigger goes out on lvdsout_trig
   logic         post_entry, done_entry;

   triggerer_top i_dut (.*);

   always #2 clklvds = ~clklvds; // 4 ns period

   assign post_entry = (acqstate == s_post) && (prev_state != s_post);
   assign done_entry = (acqstate == s_done) && (prev_state == s_post);

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic fill_samples();
      for (int k = 0; k < n_samples; k++) begin
         samplevalue[k] = sample_t'($random(seed) % 200); // noise inside thresholds
      end
      if (low_idx >= 0) samplevalue[low_idx] = sample_t'(-1000);
      if (high_idx >= 0) samplevalue[high_idx] = sample_t'(1000);
   endtask

   task automatic next_cycles(input int n);
      repeat (n) begin
         @(posedge clklvds);
         #0.5; // drive after the edge
         fill_samples();
      end
   endtask

   task automatic wait_for_state(input acq_state_t s);
      while (acqstate != s) next_cycles(1);
   endtask

   task automatic wait_writes(input int n);
      repeat (n) begin
         next_cycles(1);
         while (!ram_wr) next_cycles(1);
      end
   endtask

   task automatic apply_pattern(input int lo, input int hi);
      low_idx = lo; // first condition
      next_cycles(4);
      low_idx  = -1;
      high_idx = hi; // second condition held past tot
      next_cycles(6);
      high_idx = -1;
      next_cycles(10);
   endtask

   task automatic read_out_event();
      triggerlive = 1'b0; // no rearm after readout
      didreadout  = 1'b1;
      next_cycles(1);
      didreadout  = 1'b0;
      wait_for_state(s_ready);
   endtask

   // history for the checks below
   always @(posedge clklvds) begin
      cycle       <= cycle + 1;
      rst_q       <= arst_n;
      prev_state  <= acqstate;
      prev_addr   <= ram_wr_address;
      prev_wr     <= ram_wr;
      prev_events <= eventcounter;
      if (ram_wr) begin
         last_wr_cycle <= cycle;
         last_addr     <= ram_wr_address;
         addr_valid    <= 1'b1;
      end
      pace_valid <= check_pace && (pace_valid || ram_wr);
      post_wr    <= (acqstate == s_post) ? post_wr + int'(ram_wr) : 0;
      pulses     <= (acqstate == s_ready) ? 0 : pulses + int'(lvdsout_trig);
      if (cycle >= 4000) stop_with_failure("timeout: acquisition sequence did not finish");
   end

   a_reset_state : assert property (@(posedge clklvds) (!arst_n || !rst_q) |->
      (!ram_wr && !lvdsout_trig && !auxout && acqstate == s_ready))
      else stop_with_failure($sformatf(
         "ERROR acqstate/ram_wr/lvdsout_trig/auxout in reset expected %h/0/0/0 got %h/%h/%h/%h",
         s_ready, $sampled(acqstate), $sampled(ram_wr), $sampled(lvdsout_trig), $sampled(auxout)));
   a_wr_address : assert property (@(posedge clklvds) disable iff (!arst_n)
      ram_wr && addr_valid |-> ram_wr_address == ram_addr_t'(last_addr + 10'd1))
      else stop_with_failure($sformatf("ERROR ram_wr_address expected %h got %h",
         ram_addr_t'($sampled(last_addr) + 10'd1), $sampled(ram_wr_address)));
   a_wr_spacing : assert property (@(posedge clklvds) disable iff (!arst_n)
      check_pace && ram_wr && pace_valid |-> (cycle - last_wr_cycle) == 12) // 2^2 x 3
      else stop_with_failure($sformatf("ERROR ram_wr spacing expected %h got %h",
         12, $sampled(cycle) - $sampled(last_wr_cycle)));
   a_trig_allowed : assert property (@(posedge clklvds) disable iff (!arst_n)
      post_entry |-> trig_ok)
      else stop_with_failure("a trigger fired where none was expected");
   a_trig_addr : assert property (@(posedge clklvds) disable iff (!arst_n)
      post_entry |-> ram_address_triggered == ram_addr_t'(prev_addr - exp_tot + exp_delay))
      else stop_with_failure($sformatf("ERROR ram_address_triggered expected %h got %h",
         ram_addr_t'($sampled(prev_addr) - $sampled(exp_tot) + $sampled(exp_delay)),
         $sampled(ram_address_triggered)));
   a_trig_pulse : assert property (@(posedge clklvds) disable iff (!arst_n)
      post_entry |-> lvdsout_trig == resend_ok)
      else stop_with_failure($sformatf("ERROR lvdsout_trig expected %h got %h",
         $sampled(resend_ok), $sampled(lvdsout_trig)));
   a_pulse_on_trig : assert property (@(posedge clklvds) disable iff (!arst_n)
      lvdsout_trig |-> post_entry)
      else stop_with_failure("lvdsout_trig pulsed outside a trigger");
   a_aux_window : assert property (@(posedge clklvds) disable iff (!arst_n)
      auxout == (acqstate == s_post))
      else stop_with_failure($sformatf("ERROR auxout expected %h got %h",
         $sampled(acqstate) == s_post, $sampled(auxout)));
   a_post_len : assert property (@(posedge clklvds) disable iff (!arst_n)
      done_entry |-> (post_wr - int'(prev_wr)) == int'(lengthtotake)) // last strobe not counted
      else stop_with_failure($sformatf("ERROR post-trigger ram_wr count expected %h got %h",
         $sampled(lengthtotake), $sampled(post_wr) - int'($sampled(prev_wr))));
   a_pulse_count : assert property (@(posedge clklvds) disable iff (!arst_n)
      done_entry |-> pulses == int'(resend_ok))
      else stop_with_failure($sformatf("ERROR lvdsout_trig pulse count expected %h got %h",
         $sampled(resend_ok), $sampled(pulses)));
   a_event_count : assert property (@(posedge clklvds) disable iff (!arst_n)
      eventcounter == prev_events + done_entry)
      else stop_with_failure($sformatf("ERROR eventcounter expected %h got %h",
         $sampled(prev_events) + $sampled(done_entry), $sampled(eventcounter)));
   a_readout : assert property (@(posedge clklvds) disable iff (!arst_n)
      acqstate == s_done && didreadout |-> ##2 acqstate == s_ready) // one sync stage
      else stop_with_failure("didreadout did not return acqstate to s_ready");
   a_lvds_in : assert property (@(posedge clklvds) disable iff (!arst_n)
      acqstate == s_wait_lvds && lvdsin_trig |=> acqstate == s_post)
      else stop_with_failure("lvdsin_trig did not move acqstate to s_post");

   initial begin
      arst_n            = 1'b1;
      lvdsin_trig       = 1'b0;
      exttrigin         = 1'b0;
      triggerlive       = 1'b0;
      didreadout        = 1'b0;
      triggerchan       = 1'b0;
      channeltype       = 8'd0;
      lowerthresh       = sample_t'(-500);
      upperthresh       = sample_t'(500);
      lengthtotake      = 16'd8;
      prelengthtotake   = 16'd5;
      triggertype       = 8'd0;
      triggertot        = 8'd2;
      downsamplemerging = 8'd1;
      downsample        = 5'd0;
      fill_samples();
      #1 arst_n = 1'b0;
      repeat (10) @(posedge clklvds);
      #0.5 arst_n = 1'b1;
      next_cycles(3);
      // pacing in rising mode where quiet samples never leave s_arm
      downsample        = 5'd2;
      downsamplemerging = 8'd3;
      prelengthtotake   = 16'd3;
      triggertype       = 8'd1;
      triggerlive       = 1'b1;
      check_pace        = 1'b1;
      wait_writes(6);
      check_pace  = 1'b0;
      triggertype = 8'd0; // type change aborts
      triggerlive = 1'b0;
      wait_for_state(s_ready);
      downsample        = 5'd0; // write every cycle from here
      downsamplemerging = 8'd1;
      prelengthtotake   = 16'd5;
      // auto trigger
      triggertype = 8'd4;
      trig_ok     = 1'b1;
      resend_ok   = 1'b1;
      triggerlive = 1'b1;
      wait_for_state(s_done);
      read_out_event();
      // rising edge on channel 1 in two-channel mode
      trig_ok     = 1'b0;
      channeltype = 8'd1;
      triggerchan = 1'b1;
      triggertype = 8'd1;
      triggerlive = 1'b1;
      wait_for_state(s_arm);
      apply_pattern(3, 5); // group 0 belongs to channel 0 and is ignored
      trig_ok = 1'b1;
      apply_pattern(13, 17); // group 1
      wait_for_state(s_done);
      read_out_event();
      // lvds trigger is not re-sent
      resend_ok   = 1'b0;
      triggertype = 8'd3;
      triggerlive = 1'b1;
      wait_for_state(s_wait_lvds);
      lvdsin_trig = 1'b1;
      next_cycles(1);
      lvdsin_trig = 1'b0;
      wait_for_state(s_done);
      read_out_event();
      // external trigger with tot of 4
      trig_ok     = 1'b0;
      resend_ok   = 1'b1;
      triggertot  = 8'd4;
      exp_tot     = 10'd4;
      exp_delay   = 10'd3;
      triggertype = 8'd5;
      triggerlive = 1'b1;
      wait_for_state(s_wait_ext);
      exttrigin = 1'b1; // too short
      next_cycles(2);
      exttrigin = 1'b0;
      next_cycles(15);
      trig_ok   = 1'b1;
      exttrigin = 1'b1; // long enough
      next_cycles(10);
      exttrigin = 1'b0;
      wait_for_state(s_done);
      read_out_event();
      next_cycles(20);
      if (eventcounter != 32'd4) begin
         stop_with_failure($sformatf("ERROR eventcounter expected %h got %h",
            32'd4, eventcounter));
      end else begin
         $display("Testbench passed");
         $finish;
      end
   end

endmodule

/* files.f */
common/trig_pkg.sv
logic/config_sync.sv
logic/sample_pacer.sv
logic/threshold_compare.sv
logic/ext_trig_detect.sv
acquisition/acq_fsm.sv
logic/triggerer_top.sv
verification/tb_triggerer.sv

/* Bender.yml */
package:
  name: triggerer

sources:
  - files:
      - common/trig_pkg.sv
      - logic/config_sync.sv
      - logic/sample_pacer.sv
      - logic/threshold_compare.sv
      - logic/ext_trig_detect.sv
      - acquisition/acq_fsm.sv
      - logic/triggerer_top.sv
  - target: test
    files:
      - verification/tb_triggerer.sv

# testbench top module: tb_triggerer
# RTL top module: triggerer_top
